/* hw/bridgePkg.sv */
`default_nettype none

package bridgePkg;

	typedef logic [15:0] memAddr_t;
	typedef logic [15:0] memWord_t;
	typedef logic [7:0] uartByte_t;

	// Device behind a request
	typedef enum logic [1:0] {
		TargetUart,
		TargetRam1,
		TargetRam2
	} target_t;

	typedef struct packed {
		target_t target;
		logic write;
		memAddr_t addr;
		memWord_t data;
	} busReq_t;

	// Outputs to one SRAM chip, strobes active low
	typedef struct packed {
		memAddr_t addr;
		memWord_t wdata;
		logic drive;
		logic enN;
		logic oeN;
		logic weN;
	} sramPins_t;

	typedef struct packed {
		uartByte_t wdata;
		logic drive;
		logic rdN;
		logic wrN;
	} uartPins_t;

	localparam memAddr_t uartAddr = 16'hBF00;

endpackage

`default_nettype wire

/* hw/requestDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module requestDecoder import bridgePkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic reqStrobe,
	input wire logic reqWrite,
	input wire memAddr_t reqAddr,
	input wire memWord_t reqData,
	input wire logic full,
	output logic push,
	output busReq_t pushReq
);

	target_t target;
	logic accept;

	////////////////////
	// Address map

	always_comb begin
		if (reqAddr == uartAddr) begin
			target = TargetUart;
		end else if (reqAddr[15]) begin
			target = TargetRam1;
		end else begin
			target = TargetRam2;
		end
	end

	// Strobes seen while the queue is full are lost
	assign accept = reqStrobe && !full;

	////////////////////
	// Request register

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			push <= 1'b0;
		end else begin
			push <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pushReq.target <= target;
			pushReq.write <= reqWrite;
			pushReq.addr <= reqAddr;
			pushReq.data <= reqData;
		end
	end

endmodule

`default_nettype wire

/* hw/requestFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module requestFifo import bridgePkg::*; #(
	parameter int fifoDepth = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire busReq_t pushReq,
	input wire logic pop,
	output busReq_t head,
	output logic full,
	output logic empty
);

	// Depth is a power of two, at least 2, so the pointers wrap by themselves
	localparam int ptrW = $clog2(fifoDepth);

	typedef logic [ptrW-1:0] ptr_t;
	typedef logic [ptrW:0] count_t;

	busReq_t slots [fifoDepth];
	ptr_t wrPtr;
	ptr_t rdPtr;
	count_t count;
	count_t nextCount;
	logic doPush;
	logic doPop;

	assign doPush = push && (count != count_t'(fifoDepth));
	assign doPop = pop && !empty;

	always_comb begin
		case ({doPush, doPop})
			2'b10: nextCount = count + 1'b1;
			2'b01: nextCount = count - 1'b1;
			default: nextCount = count;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			count <= nextCount;
			// Raised one slot early, the decoder may still have a push in flight
			full <= nextCount >= count_t'(fifoDepth - 1);
			empty <= nextCount == '0;
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) begin
			slots[wrPtr] <= pushReq;
		end
	end

	assign head = slots[rdPtr];

endmodule

`default_nettype wire

/* hw/busController.sv */
`timescale 1ns/1ns
`default_nettype none

module busController import bridgePkg::*; #(
	parameter int stepCycles = 2
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic empty,
	input wire busReq_t head,
	input wire memWord_t ram1Rdata,
	input wire memWord_t ram2Rdata,
	input wire uartByte_t uartRdata,
	input wire logic dataReady,
	input wire logic tbre,
	input wire logic tsre,
	output logic pop,
	output sramPins_t ram1,
	output sramPins_t ram2,
	output uartPins_t uart,
	output logic respDone,
	output memWord_t respData
);

	localparam int cntW = (stepCycles > 1) ? $clog2(stepCycles) : 1;

	typedef enum logic [4:0] {
		Idle,
		RamRead1, RamRead2, RamRead3,
		RamWrite1, RamWrite2, RamWrite3,
		UartWLoad1, UartWStrobe1, UartWTbre1, UartWTsre1,
		UartWLoad2, UartWStrobe2, UartWTbre2, UartWTsre2,
		UartRWait1, UartRStrobe1, UartRRelease1,
		UartRWait2, UartRStrobe2, UartRRelease2
	} ctrlState_t;

	ctrlState_t state;
	ctrlState_t nextState;
	logic [cntW-1:0] stepCnt;
	logic stepEnd;
	logic done;
	busReq_t req;
	uartByte_t hiByte;
	memWord_t rdWord;

	////////////////////
	// Step timing

	assign stepEnd = stepCnt == cntW'(stepCycles - 1);
	assign pop = (state == Idle) && stepEnd && !empty;
	// Last step of any request
	assign done = stepEnd && (state != Idle) && (nextState == Idle);

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (!empty) begin
					if (head.target == TargetUart) begin
						nextState = head.write ? UartWLoad1 : UartRWait1;
					end else begin
						nextState = head.write ? RamWrite1 : RamRead1;
					end
				end
			end
			RamRead1: nextState = RamRead2;
			RamRead2: nextState = RamRead3;
			RamRead3: nextState = Idle;
			RamWrite1: nextState = RamWrite2;
			RamWrite2: nextState = RamWrite3;
			RamWrite3: nextState = Idle;
			// High byte first
			UartWLoad1: nextState = UartWStrobe1;
			UartWStrobe1: nextState = UartWTbre1;
			UartWTbre1: nextState = tbre ? UartWTsre1 : UartWTbre1;
			UartWTsre1: nextState = tsre ? UartWLoad2 : UartWTsre1;
			UartWLoad2: nextState = UartWStrobe2;
			UartWStrobe2: nextState = UartWTbre2;
			UartWTbre2: nextState = tbre ? UartWTsre2 : UartWTbre2;
			UartWTsre2: nextState = tsre ? Idle : UartWTsre2;
			UartRWait1: nextState = dataReady ? UartRStrobe1 : UartRWait1;
			UartRStrobe1: nextState = UartRRelease1;
			UartRRelease1: nextState = UartRWait2;
			UartRWait2: nextState = dataReady ? UartRStrobe2 : UartRWait2;
			UartRStrobe2: nextState = UartRRelease2;
			UartRRelease2: nextState = Idle;
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= Idle;
			stepCnt <= '0;
			respDone <= 1'b0;
		end else begin
			respDone <= done;
			if (stepEnd) begin
				stepCnt <= '0;
				state <= nextState;
			end else begin
				stepCnt <= stepCnt + 1'b1;
			end
		end
	end

	////////////////////
	// Request and read data

	always_ff @(posedge clk) begin
		if (pop) begin
			req <= head;
		end
		if (stepEnd) begin
			case (state)
				RamRead2: rdWord <= (req.target == TargetRam1) ? ram1Rdata : ram2Rdata;
				UartRStrobe1: hiByte <= uartRdata;
				UartRStrobe2: rdWord <= {hiByte, uartRdata};
				default: ;
			endcase
		end
		// Word is published together with respDone
		if (done && !req.write) begin
			respData <= rdWord;
		end
	end

	////////////////////
	// Pin decode

	function automatic sramPins_t ramPins(input logic sel, input ctrlState_t st,
			input busReq_t r);
		sramPins_t p;
		logic active;
		active = sel && (st inside {RamRead1, RamRead2, RamRead3,
			RamWrite1, RamWrite2, RamWrite3});
		p.addr = r.addr;
		p.wdata = r.data;
		p.drive = active && r.write;
		p.enN = !active;
		p.oeN = !(active && st == RamRead2);
		p.weN = !(active && st == RamWrite2);
		return p;
	endfunction

	assign ram1 = ramPins(req.target == TargetRam1, state, req);
	assign ram2 = ramPins(req.target == TargetRam2, state, req);

	always_comb begin
		uart.wdata = (state inside {UartWLoad2, UartWStrobe2}) ? req.data[7:0] : req.data[15:8];
		uart.drive = state inside {UartWLoad1, UartWStrobe1, UartWLoad2, UartWStrobe2};
		uart.rdN = !(state inside {UartRStrobe1, UartRStrobe2});
		uart.wrN = !(state inside {UartWStrobe1, UartWStrobe2});
	end

endmodule

`default_nettype wire

/* hw/memBridge.sv */
`timescale 1ns/1ns
`default_nettype none

module memBridge import bridgePkg::*; #(
	parameter int stepCycles = 2,
	parameter int fifoDepth = 4
) (
	input wire logic clk,
	input wire logic rst,
	// Processor side
	input wire logic reqStrobe,
	input wire logic reqWrite,
	input wire memAddr_t reqAddr,
	input wire memWord_t reqData,
	output logic busy,
	output logic respDone,
	output memWord_t respData,
	// Board side
	output sramPins_t ram1,
	input wire memWord_t ram1Rdata,
	output sramPins_t ram2,
	input wire memWord_t ram2Rdata,
	output uartPins_t uart,
	input wire uartByte_t uartRdata,
	input wire logic dataReady,
	input wire logic tbre,
	input wire logic tsre
);

	logic push;
	busReq_t pushReq;
	busReq_t head;
	logic full;
	logic empty;
	logic pop;

	assign busy = full;

	requestDecoder i_requestDecoder (
		.clk(clk),
		.rst(rst),
		.reqStrobe(reqStrobe),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.full(full),
		.push(push),
		.pushReq(pushReq)
	);

	requestFifo #(
		.fifoDepth(fifoDepth)
	) i_requestFifo (
		.clk(clk),
		.rst(rst),
		.push(push),
		.pushReq(pushReq),
		.pop(pop),
		.head(head),
		.full(full),
		.empty(empty)
	);

	busController #(
		.stepCycles(stepCycles)
	) i_busController (
		.clk(clk),
		.rst(rst),
		.empty(empty),
		.head(head),
		.ram1Rdata(ram1Rdata),
		.ram2Rdata(ram2Rdata),
		.uartRdata(uartRdata),
		.dataReady(dataReady),
		.tbre(tbre),
		.tsre(tsre),
		.pop(pop),
		.ram1(ram1),
		.ram2(ram2),
		.uart(uart),
		.respDone(respDone),
		.respData(respData)
	);

endmodule

`default_nettype wire

/* verification/boardModels.sv */
`timescale 1ns/1ns
`default_nettype none

// Asynchronous SRAM chip, 64K words
module sramModel import bridgePkg::*; (
	input wire logic clk,
	input wire sramPins_t pins,
	output memWord_t rdata
);

	memWord_t mem [65536];
	logic weD = 1'b1;

	assign rdata = (!pins.enN && !pins.oeN) ? mem[pins.addr] : '0;

	// Write lands on the rising edge of weN
	always @(posedge clk) begin
		weD <= pins.weN;
		if (pins.weN && !weD && !pins.enN) begin
			mem[pins.addr] <= pins.wdata;
		end
	end

endmodule

// Byte-wide UART chip with a transmit log and a preloaded receive list
module uartModel import bridgePkg::*; (
	input wire logic clk,
	input wire uartPins_t pins,
	output uartByte_t rdata,
	output logic dataReady,
	output logic tbre,
	output logic tsre
);

	uartByte_t txLog [$];
	uartByte_t rxMem [16];
	int rxCount = 0;
	int rxIdx = 0;
	int busyCnt = 0;
	logic wrD = 1'b1;
	logic rdD = 1'b1;
	uartByte_t wdataD = '0;

	// Holding register frees up before the shifter does
	assign tbre = busyCnt < 10;
	assign tsre = busyCnt == 0;
	assign dataReady = rxIdx < rxCount;
	assign rdata = rxMem[rxIdx[3:0]];

	always @(posedge clk) begin
		wrD <= pins.wrN;
		rdD <= pins.rdN;
		wdataD <= pins.wdata;
		// Byte on the bus while wrN was low
		if (pins.wrN && !wrD) begin
			txLog.push_back(wdataD);
			busyCnt <= 16;
		end else if (busyCnt != 0) begin
			busyCnt <= busyCnt - 1;
		end
		if (pins.rdN && !rdD) begin
			rxIdx <= rxIdx + 1;
		end
	end

endmodule

`default_nettype wire

/* verification/memBridgeTb.sv */
`timescale 1ns/1ns
`default_nettype none

module memBridgeTb import bridgePkg::*; ();

	// About 400 cycles of traffic, wide margin for the UART stalls
	localparam int timeoutCycles = 3000;

	logic clk;
	logic rst;
	logic reqStrobe;
	logic reqWrite;
	memAddr_t reqAddr;
	memWord_t reqData;
	logic busy;
	logic respDone;
	memWord_t respData;
	sramPins_t ram1Pins;
	sramPins_t ram2Pins;
	uartPins_t uartPins;
	memWord_t ram1Rdata;
	memWord_t ram2Rdata;
	uartByte_t uartRdata;
	logic dataReady;
	logic tbre;
	logic tsre;

	logic [15:0] lfsr = 16'd25;
	memWord_t refMem [memAddr_t];
	string expName [$];
	logic expRead [$];
	memWord_t expData [$];
	uartByte_t txExp [$];
	logic waitedBusy = 1'b0;
	int cycles = 0;

	memBridge #(
		.stepCycles(2),
		.fifoDepth(4)
	) i_memBridge (
		.clk(clk),
		.rst(rst),
		.reqStrobe(reqStrobe),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.busy(busy),
		.respDone(respDone),
		.respData(respData),
		.ram1(ram1Pins),
		.ram1Rdata(ram1Rdata),
		.ram2(ram2Pins),
		.ram2Rdata(ram2Rdata),
		.uart(uartPins),
		.uartRdata(uartRdata),
		.dataReady(dataReady),
		.tbre(tbre),
		.tsre(tsre)
	);

	sramModel i_ram1 (.clk(clk), .pins(ram1Pins), .rdata(ram1Rdata));
	sramModel i_ram2 (.clk(clk), .pins(ram2Pins), .rdata(ram2Rdata));

	uartModel i_uart (
		.clk(clk),
		.pins(uartPins),
		.rdata(uartRdata),
		.dataReady(dataReady),
		.tbre(tbre),
		.tsre(tsre)
	);

	always #5 clk = ~clk;

	////////////////////
	// Failure reporting

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic valueMismatch(input string name, input memWord_t expWord,
			input memWord_t actWord);
		abortRun($sformatf("CHECK FAILED %s expected %h actual %h", name, expWord, actWord));
	endtask

	////////////////////
	// Stimulus helpers

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic nextBits(input int count, output memWord_t value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsrNext(lfsr);
			value = {value[14:0], lfsr[0]};
		end
	endtask

	// For a UART read, data is the word the UART model will deliver
	task automatic sendRequest(input logic write, input memAddr_t addr, input memWord_t data,
			input string name);
		memWord_t expWord;
		expWord = '0;
		if (write && addr == uartAddr) begin
			txExp.push_back(data[15:8]);
			txExp.push_back(data[7:0]);
		end else if (write) begin
			refMem[addr] = data;
		end else if (addr == uartAddr) begin
			i_uart.rxMem[i_uart.rxCount[3:0]] = data[15:8];
			i_uart.rxMem[4'(i_uart.rxCount + 1)] = data[7:0];
			i_uart.rxCount = i_uart.rxCount + 2;
			expWord = data;
		end else begin
			expWord = refMem[addr];
		end
		while (busy) begin
			waitedBusy = 1'b1;
			@(posedge clk);
			#1;
		end
		reqStrobe = 1'b1;
		reqWrite = write;
		reqAddr = addr;
		reqData = data;
		expName.push_back(name);
		expRead.push_back(!write);
		expData.push_back(expWord);
		@(posedge clk);
		#1;
		reqStrobe = 1'b0;
	endtask

	task automatic drainResponses();
		while (expData.size() != 0) begin
			@(posedge clk);
			#1;
		end
		// A few quiet cycles to catch a stray respDone
		repeat (4) @(posedge clk);
		#1;
	endtask

	////////////////////
	// Checks

	task automatic checkIdlePins(input string name);
		logic [10:0] seen;
		// Eight strobes high, then drive, busy and respDone low
		seen = {ram1Pins.enN, ram1Pins.oeN, ram1Pins.weN,
			ram2Pins.enN, ram2Pins.oeN, ram2Pins.weN, uartPins.rdN, uartPins.wrN,
			ram1Pins.drive | ram2Pins.drive | uartPins.drive, busy, respDone};
		assert (seen == 11'h7F8) else valueMismatch(name, 16'h07F8, 16'(seen));
	endtask

	task automatic compareTxLog(input string name);
		assert (i_uart.txLog.size() == txExp.size())
			else abortRun($sformatf("%s: the UART got %0d bytes where %0d were sent", name,
				i_uart.txLog.size(), txExp.size()));
		for (int i = 0; i < txExp.size(); i++) begin
			assert (i_uart.txLog[i] == txExp[i])
				else valueMismatch(name, 16'(txExp[i]), 16'(i_uart.txLog[i]));
		end
	endtask

	// Only one device on the board buses at a time
	assert property (@(posedge clk) disable iff (!rst) ram1Pins.enN || ram2Pins.enN)
		else abortRun("Both SRAM chips were enabled at once");
	assert property (@(posedge clk) disable iff (!rst)
		(!ram1Pins.enN || !ram2Pins.enN) |-> (uartPins.rdN && uartPins.wrN))
		else abortRun("A UART strobe went low during an SRAM transfer");

	// Each SRAM chip only sees addresses from its own part of the map
	assert property (@(posedge clk) disable iff (!rst)
		(ram1Pins.enN || (ram1Pins.addr[15] && ram1Pins.addr != uartAddr))
		&& (ram2Pins.enN || !ram2Pins.addr[15]))
		else abortRun("An SRAM chip was enabled for an address outside its range");

	// Data buses driven while writing and released while reading
	assert property (@(posedge clk) disable iff (!rst)
		(ram1Pins.weN || ram1Pins.drive) && (ram1Pins.oeN || !ram1Pins.drive)
		&& (ram2Pins.weN || ram2Pins.drive) && (ram2Pins.oeN || !ram2Pins.drive)
		&& (uartPins.wrN || uartPins.drive) && (uartPins.rdN || !uartPins.drive))
		else abortRun("A data bus drive bit did not match the strobe in progress");

	// Responses in request order
	always @(posedge clk) begin
		if (respDone) begin
			assert (expData.size() != 0) else abortRun("respDone pulsed with no request pending");
			if (expRead[0]) begin
				assert (respData == expData[0])
					else valueMismatch(expName[0], expData[0], respData);
			end
			void'(expName.pop_front());
			void'(expRead.pop_front());
			void'(expData.pop_front());
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == timeoutCycles) begin
			abortRun($sformatf("The run hung and did not finish within %0d cycles",
				timeoutCycles));
		end
	end

	////////////////////
	// Test sequence

	initial begin
		memAddr_t ramAddr [4];
		memWord_t word;
		clk = 1'b0;
		rst = 1'b0;
		reqStrobe = 1'b0;
		reqWrite = 1'b0;
		reqAddr = '0;
		reqData = '0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;
		repeat (3) begin
			checkIdlePins("reset");
			@(posedge clk);
			#1;
		end

		// RAM2 twins share the low address bits
		for (int i = 0; i < 4; i++) begin
			nextBits(10, word);
			ramAddr[i] = 16'h8000 | word;
			nextBits(16, word);
			sendRequest(1'b1, ramAddr[i], word, "ram1 write");
			nextBits(16, word);
			sendRequest(1'b1, ramAddr[i] & 16'h7FFF, word, "ram2 write");
		end
		for (int i = 0; i < 4; i++) begin
			sendRequest(1'b0, ramAddr[i], '0, "ram1 readback");
			sendRequest(1'b0, ramAddr[i] & 16'h7FFF, '0, "ram2 readback");
		end
		drainResponses();

		nextBits(16, word);
		sendRequest(1'b1, uartAddr, word, "uart write");
		drainResponses();
		compareTxLog("uart write");

		nextBits(16, word);
		sendRequest(1'b0, uartAddr, word, "uart read");
		drainResponses();

		// Slow UART write at the head, RAM traffic piling up behind it
		waitedBusy = 1'b0;
		nextBits(16, word);
		sendRequest(1'b1, uartAddr, word, "back-pressure");
		for (int i = 0; i < 4; i++) begin
			nextBits(16, word);
			sendRequest(1'b1, ramAddr[i], word, "back-pressure");
			sendRequest(1'b0, ramAddr[i] & 16'h7FFF, '0, "back-pressure");
		end
		nextBits(16, word);
		sendRequest(1'b0, uartAddr, word, "back-pressure");
		sendRequest(1'b0, ramAddr[0], '0, "back-pressure");
		drainResponses();
		compareTxLog("back-pressure");
		assert (waitedBusy) else abortRun("busy never rose while the UART was stalled");

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
hw/bridgePkg.sv
hw/requestDecoder.sv
hw/requestFifo.sv
hw/busController.sv
hw/memBridge.sv
verification/boardModels.sv
verification/memBridgeTb.sv

/* Makefile */
# Verilator flow for the memory bridge testbench

VERILATOR ?= verilator
TOP ?= memBridgeTb
FILELIST ?= sim.f
BUILD_DIR ?= build
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: $(SIM_BIN)
	$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
